/* hw/pcs_err_pkg.sv */
package pcs_err_pkg;

        // widths
        localparam int NB_BLOCK      = 66;          // coded block incl sync header
        localparam int NB_PAYLOAD    = 64;
        localparam int NB_SH         = 2;
        localparam int NB_MODE       = 4;           // one-hot break mode
        localparam int NB_BURST_CNT  = 10;
        localparam int NB_PERIOD_CNT = 10;
        localparam int NB_REPEAT_CNT = 4;
        localparam int NB_STAT_CNT   = 32;
        localparam int NB_FLIP_CNT   = 7;           // holds popcount of a full block
        localparam int NB_RF_ADDR    = 4;
        localparam int NB_RF_DATA    = 32;

        typedef logic [NB_BLOCK-1:0]      block_t;
        typedef logic [NB_PAYLOAD-1:0]    payload_t;    // also the error mask
        typedef logic [NB_SH-1:0]         sh_t;
        typedef logic [NB_MODE-1:0]       mode_t;
        typedef logic [NB_BURST_CNT-1:0]  burst_cnt_t;
        typedef logic [NB_PERIOD_CNT-1:0] period_cnt_t;
        typedef logic [NB_REPEAT_CNT-1:0] repeat_cnt_t;
        typedef logic [NB_STAT_CNT-1:0]   stat_cnt_t;
        typedef logic [NB_FLIP_CNT-1:0]   flip_cnt_t;
        typedef logic [NB_RF_ADDR-1:0]    rf_addr_t;
        typedef logic [NB_RF_DATA-1:0]    rf_data_t;

        // sync header, top two bits of a block
        localparam sh_t SH_CTRL = 2'b10;
        localparam sh_t SH_DATA = 2'b01;

        localparam mode_t MODE_OFF   = 4'b0000;     // pass everything
        localparam mode_t MODE_ALIGN = 4'b0001;     // aligner blocks only
        localparam mode_t MODE_CTRL  = 4'b0010;
        localparam mode_t MODE_DATA  = 4'b0100;
        localparam mode_t MODE_ALL   = 4'b1000;

        // alignment marker, sent as SH_CTRL + AM_PAYLOAD
        localparam int       AM_SPACING = 32;
        localparam int       NB_AM_CNT  = $clog2(AM_SPACING);
        localparam payload_t AM_PAYLOAD = 64'h9076_4700_6f89_b8ff;

        // register map
        localparam rf_addr_t RA_MODE    = 4'd0;
        localparam rf_addr_t RA_MASK_LO = 4'd1;
        localparam rf_addr_t RA_MASK_HI = 4'd2;
        localparam rf_addr_t RA_BURST   = 4'd3;
        localparam rf_addr_t RA_PERIOD  = 4'd4;
        localparam rf_addr_t RA_REPEAT  = 4'd5;
        localparam rf_addr_t RA_COMMIT  = 4'd6;     // write-only pulse
        localparam rf_addr_t RA_CLEAR   = 4'd7;     // write-only pulse
        localparam rf_addr_t RA_BROKEN  = 4'd8;
        localparam rf_addr_t RA_FLIPS   = 4'd9;

endpackage

/* hw/am_tagger.sv */
`timescale 1ns/100ps

module am_tagger import pcs_err_pkg::*;
(
        input  logic   i_clock,
        input  logic   i_reset,
        input  logic   i_valid,
        input  block_t i_block,
        output logic   o_valid,
        output logic   o_aligner_tag,      // high on marker blocks
        output block_t o_block
);

        logic [NB_AM_CNT-1:0] am_cnt;       // valid blocks since last marker
        logic                 am_last;      // this block becomes the marker
        logic                 am_insert;

        assign am_last   = (am_cnt == NB_AM_CNT'(AM_SPACING - 1));
        assign am_insert = i_valid & am_last;

        // block position counter, idle cycles hold it
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        am_cnt <= '0;
                else if (i_valid)
                begin
                        if (am_last)
                                am_cnt <= '0;
                        else
                                am_cnt <= am_cnt + 1'b1;
                end
        end

        // output stage
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        o_valid       <= 1'b0;
                        o_aligner_tag <= 1'b0;
                end
                else
                begin
                        o_valid       <= i_valid;
                        o_aligner_tag <= am_insert;     // never set on idle cycles
                end
        end

        // payload register, no reset
        always_ff @(posedge i_clock)
        begin
                if (am_insert)
                        o_block <= {SH_CTRL, AM_PAYLOAD};  // marker replaces the block
                else
                        o_block <= i_block;
        end

endmodule

/* hw/payload_breaker.sv */
`timescale 1ns/100ps

module payload_breaker import pcs_err_pkg::*;
(
        input  logic        i_clock,
        input  logic        i_reset,
        input  logic        i_valid,
        input  logic        i_aligner_tag,
        input  block_t      i_data,
        input  mode_t       i_rf_mode,
        input  logic        i_rf_update,        // load config, one cycle
        input  payload_t    i_rf_error_mask,    // 1 = invert that payload bit
        input  burst_cnt_t  i_rf_error_burst,   // broken blocks per period
        input  period_cnt_t i_rf_error_period,  // blocks per period
        input  repeat_cnt_t i_rf_error_repeat,  // number of extra periods
        output block_t      o_data,
        output logic        o_aligner_tag,
        output logic        o_valid
);

        mode_t       mode_q;
        payload_t    mask_q;
        burst_cnt_t  burst_q;
        period_cnt_t period_q;
        repeat_cnt_t repeat_q;

        sh_t         sh;
        payload_t    payload;
        logic        burst_on;
        logic        period_on;
        logic        repeat_on;
        logic        mode_match;    // block is of the selected kind
        logic        break_en;
        logic        reload;        // period ran out, start the next one

        assign sh      = i_data[NB_BLOCK-1 -: NB_SH];
        assign payload = i_data[NB_PAYLOAD-1:0];

        assign burst_on  = (burst_q != '0);
        assign period_on = (period_q != '0);
        assign repeat_on = (repeat_q != '0);

        assign mode_match = ((mode_q == MODE_ALIGN) & i_aligner_tag)   |
                            ((mode_q == MODE_CTRL)  & (sh == SH_CTRL)) |
                            ((mode_q == MODE_DATA)  & (sh == SH_DATA)) |
                             (mode_q == MODE_ALL);              // MODE_OFF matches nothing

        // update cycle block always passes clean
        assign break_en = i_valid & ~i_rf_update & burst_on & mode_match;
        assign reload   = i_valid & ~i_rf_update & ~period_on & repeat_on;

        // header kept, masked payload bits inverted
        assign o_data        = break_en ? {sh, payload ^ mask_q} : i_data;
        assign o_aligner_tag = i_aligner_tag;
        assign o_valid       = i_valid;

        // mode and mask load on update alone
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        mode_q <= MODE_OFF;
                        mask_q <= '0;
                end
                else if (i_rf_update)
                begin
                        mode_q <= i_rf_mode;
                        mask_q <= i_rf_error_mask;
                end
        end

        // burst counter, counts only broken blocks
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        burst_q <= '0;
                else if (i_rf_update)
                        burst_q <= i_rf_error_burst;
                else if (reload)
                        burst_q <= i_rf_error_burst;
                else if (break_en)
                        burst_q <= burst_q - 1'b1;
        end

        // period counter, one step per valid block
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        period_q <= '0;
                else if (i_rf_update)
                        period_q <= i_rf_error_period;
                else if (reload)
                        period_q <= i_rf_error_period;
                else if (i_valid && period_on)
                        period_q <= period_q - 1'b1;
        end

        // repeat counter
        // steps once both period and burst are spent, valid or not
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        repeat_q <= '0;
                else if (i_rf_update)
                        repeat_q <= i_rf_error_repeat;
                else if (repeat_on && !period_on && !burst_on)
                        repeat_q <= repeat_q - 1'b1;
        end

endmodule

/* hw/break_monitor.sv */
`timescale 1ns/100ps

module break_monitor import pcs_err_pkg::*;
(
        input  logic      i_clock,
        input  logic      i_reset,
        input  logic      i_clear,          // zero both counts
        input  logic      i_valid,
        input  block_t    i_block_in,       // breaker input
        input  block_t    i_block_out,      // breaker output
        output stat_cnt_t o_broken_blocks,
        output stat_cnt_t o_flipped_bits
);

        block_t    diff;            // bits changed by the breaker
        flip_cnt_t flip_cnt;
        logic      is_broken;

        assign diff      = i_block_in ^ i_block_out;
        assign is_broken = |diff;

        // popcount of the difference
        always_comb
        begin
                flip_cnt = '0;
                for (int i = 0; i < NB_BLOCK; i++)
                        flip_cnt = flip_cnt + flip_cnt_t'(diff[i]);
        end

        // broken block count
        always_ff @(posedge i_clock)
        begin
                if (i_reset || i_clear)
                        o_broken_blocks <= '0;
                else if (i_valid && is_broken)
                        o_broken_blocks <= o_broken_blocks + 1'b1;   // wraps at 32 bits
        end

        // flipped bit total
        always_ff @(posedge i_clock)
        begin
                if (i_reset || i_clear)
                        o_flipped_bits <= '0;
                else if (i_valid)
                        o_flipped_bits <= o_flipped_bits + stat_cnt_t'(flip_cnt);
        end

endmodule

/* hw/err_rf.sv */
`timescale 1ns/100ps

module err_rf import pcs_err_pkg::*;
(
        input  logic        i_clock,
        input  logic        i_reset,
        input  logic        i_wr,
        input  logic        i_rd,
        input  rf_addr_t    i_addr,
        input  rf_data_t    i_wdata,
        input  stat_cnt_t   i_broken_blocks,
        input  stat_cnt_t   i_flipped_bits,
        output rf_data_t    o_rd_data,      // valid the cycle after i_rd
        output mode_t       o_mode,
        output payload_t    o_mask,
        output burst_cnt_t  o_burst,
        output period_cnt_t o_period,
        output repeat_cnt_t o_repeat,
        output logic        o_update,       // one cycle after commit write
        output logic        o_clear
);

        rf_data_t rd_mux;

        // shadow config registers
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        o_mode   <= MODE_OFF;
                        o_mask   <= '0;
                        o_burst  <= '0;
                        o_period <= '0;
                        o_repeat <= '0;
                end
                else if (i_wr)
                begin
                        case (i_addr)
                                RA_MODE    : o_mode   <= i_wdata[NB_MODE-1:0];
                                RA_MASK_LO : o_mask[NB_RF_DATA-1:0] <= i_wdata;
                                RA_MASK_HI : o_mask[NB_PAYLOAD-1:NB_RF_DATA] <= i_wdata;
                                RA_BURST   : o_burst  <= i_wdata[NB_BURST_CNT-1:0];
                                RA_PERIOD  : o_period <= i_wdata[NB_PERIOD_CNT-1:0];
                                RA_REPEAT  : o_repeat <= i_wdata[NB_REPEAT_CNT-1:0];
                                default    : ;  // pulses and read-only
                        endcase
                end
        end

        // commit and clear strobes
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        o_update <= 1'b0;
                        o_clear  <= 1'b0;
                end
                else
                begin
                        o_update <= i_wr && (i_addr == RA_COMMIT);
                        o_clear  <= i_wr && (i_addr == RA_CLEAR);
                end
        end

        // read mux
        always_comb
        begin
                case (i_addr)
                        RA_MODE    : rd_mux = rf_data_t'(o_mode);
                        RA_MASK_LO : rd_mux = o_mask[NB_RF_DATA-1:0];
                        RA_MASK_HI : rd_mux = o_mask[NB_PAYLOAD-1:NB_RF_DATA];
                        RA_BURST   : rd_mux = rf_data_t'(o_burst);
                        RA_PERIOD  : rd_mux = rf_data_t'(o_period);
                        RA_REPEAT  : rd_mux = rf_data_t'(o_repeat);
                        RA_BROKEN  : rd_mux = i_broken_blocks;
                        RA_FLIPS   : rd_mux = i_flipped_bits;
                        default    : rd_mux = '0;       // commit, clear, unmapped
                endcase
        end

        // read data holds until the next read
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        o_rd_data <= '0;
                else if (i_rd)
                        o_rd_data <= rd_mux;
        end

endmodule

/* hw/pcs_err_inject_top.sv */
`timescale 1ns/100ps

module pcs_err_inject_top import pcs_err_pkg::*;
(
        input  logic     i_clock,
        input  logic     i_reset,
        input  logic     i_valid,
        input  block_t   i_block,
        input  logic     i_wr,
        input  logic     i_rd,
        input  rf_addr_t i_addr,
        input  rf_data_t i_wdata,
        output rf_data_t o_rd_data,
        output logic     o_valid,
        output logic     o_aligner_tag,
        output block_t   o_block
);

        // tagged stream, tagger to breaker and monitor
        logic        tag_valid;
        logic        tag_aligner;
        block_t      tag_block;

        // config from the register file
        mode_t       cfg_mode;
        payload_t    cfg_mask;
        burst_cnt_t  cfg_burst;
        period_cnt_t cfg_period;
        repeat_cnt_t cfg_repeat;
        logic        cfg_update;

        // statistics
        logic        stat_clear;
        stat_cnt_t   stat_broken;
        stat_cnt_t   stat_flips;

        am_tagger am_tagger_i (
                .i_clock       (i_clock),
                .i_reset       (i_reset),
                .i_valid       (i_valid),
                .i_block       (i_block),
                .o_valid       (tag_valid),
                .o_aligner_tag (tag_aligner),
                .o_block       (tag_block)
        );

        payload_breaker payload_breaker_i (
                .i_clock           (i_clock),
                .i_reset           (i_reset),
                .i_valid           (tag_valid),
                .i_aligner_tag     (tag_aligner),
                .i_data            (tag_block),
                .i_rf_mode         (cfg_mode),
                .i_rf_update       (cfg_update),
                .i_rf_error_mask   (cfg_mask),
                .i_rf_error_burst  (cfg_burst),
                .i_rf_error_period (cfg_period),
                .i_rf_error_repeat (cfg_repeat),
                .o_data            (o_block),
                .o_aligner_tag     (o_aligner_tag),
                .o_valid           (o_valid)
        );

        break_monitor break_monitor_i (
                .i_clock         (i_clock),
                .i_reset         (i_reset),
                .i_clear         (stat_clear),
                .i_valid         (tag_valid),
                .i_block_in      (tag_block),
                .i_block_out     (o_block),     // compared against breaker input
                .o_broken_blocks (stat_broken),
                .o_flipped_bits  (stat_flips)
        );

        err_rf err_rf_i (
                .i_clock         (i_clock),
                .i_reset         (i_reset),
                .i_wr            (i_wr),
                .i_rd            (i_rd),
                .i_addr          (i_addr),
                .i_wdata         (i_wdata),
                .i_broken_blocks (stat_broken),
                .i_flipped_bits  (stat_flips),
                .o_rd_data       (o_rd_data),
                .o_mode          (cfg_mode),
                .o_mask          (cfg_mask),
                .o_burst         (cfg_burst),
                .o_period        (cfg_period),
                .o_repeat        (cfg_repeat),
                .o_update        (cfg_update),
                .o_clear         (stat_clear)
        );

endmodule

/* sim/payload_breaker_chk.sv */
`timescale 1ns/100ps

module payload_breaker_chk import pcs_err_pkg::*;
(
        input logic   i_clock,
        input logic   i_reset,
        input logic   i_valid,
        input logic   i_aligner_tag,
        input block_t i_data,
        input logic   i_update,
        input mode_t  i_mode,           // breaker mode register
        input block_t i_out_data,
        input logic   i_out_tag,
        input logic   i_out_valid
);

        int n_fail = 0;         // failed assertion count

        // header and tag never touched
        sh_tag_kept: assert property (@(posedge i_clock) disable iff (i_reset)
                (i_out_data[NB_BLOCK-1 -: NB_SH] == i_data[NB_BLOCK-1 -: NB_SH]) &&
                (i_out_tag == i_aligner_tag))
        else
        begin
                n_fail++;
                $error("breaker altered the sync header or the aligner tag");
        end

        valid_passed: assert property (@(posedge i_clock) disable iff (i_reset)
                i_out_valid == i_valid)
        else
        begin
                n_fail++;
                $error("breaker output valid differs from its input valid");
        end

        // update block and mode off pass clean
        clean_pass: assert property (@(posedge i_clock) disable iff (i_reset)
                (i_update || i_mode == MODE_OFF) |-> (i_out_data == i_data))
        else
        begin
                n_fail++;
                $error("block changed on an update cycle or with the mode off");
        end

endmodule

bind payload_breaker payload_breaker_chk payload_breaker_chk_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_aligner_tag (i_aligner_tag),
        .i_data        (i_data),
        .i_update      (i_rf_update),
        .i_mode        (mode_q),
        .i_out_data    (o_data),
        .i_out_tag     (o_aligner_tag),
        .i_out_valid   (o_valid)
);

/* sim/pcs_err_inject_tb.sv */
`timescale 1ns/100ps

module pcs_err_inject_tb import pcs_err_pkg::*;
();

        logic        clock;
        logic        reset;
        logic        in_valid;
        block_t      in_block;
        logic        wr;
        logic        rd;
        rf_addr_t    addr;
        rf_data_t    wdata;
        rf_data_t    rd_data;
        logic        out_valid;
        logic        out_tag;
        block_t      out_block;

        int          len_short  = 300;       // blocks per plain run
        int          len_long   = 800;       // align run, repeats get spent
        int          n_checks   = 0;
        int          n_errors   = 0;
        string       test_name  = "reset";
        logic [31:0] lfsr;
        rf_data_t    rd_capture;             // o_rd_data at the last step

        // reference model state
        int          m_am_cnt    = 0;
        logic        m_tag_valid = 1'b0;     // tagger output stage
        logic        m_tag_tag   = 1'b0;
        block_t      m_tag_blk   = '0;
        logic        m_update    = 1'b0;     // commit pulse seen by the breaker
        logic        m_clear     = 1'b0;
        mode_t       s_mode      = MODE_OFF; // register file shadows
        payload_t    s_mask      = '0;
        burst_cnt_t  s_burst     = '0;
        period_cnt_t s_period    = '0;
        repeat_cnt_t s_repeat    = '0;
        mode_t       b_mode      = MODE_OFF; // breaker registers
        payload_t    b_mask      = '0;
        burst_cnt_t  b_burst     = '0;
        period_cnt_t b_period    = '0;
        repeat_cnt_t b_repeat    = '0;
        stat_cnt_t   m_broken    = '0;
        stat_cnt_t   m_flips     = '0;

        pcs_err_inject_top pcs_err_inject_top_i (
                .i_clock       (clock),
                .i_reset       (reset),
                .i_valid       (in_valid),
                .i_block       (in_block),
                .i_wr          (wr),
                .i_rd          (rd),
                .i_addr        (addr),
                .i_wdata       (wdata),
                .o_rd_data     (rd_data),
                .o_valid       (out_valid),
                .o_aligner_tag (out_tag),
                .o_block       (out_block)
        );

        always #2 clock = ~clock;       // 4 ns period

        // galois lfsr, right shift, taps 32 30 26 25
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
        endfunction

        function automatic logic [63:0] random_bits(input int n);
                logic [63:0] r;
                r = '0;
                for (int i = 0; i < n; i++)
                begin
                        lfsr = lfsr_step(lfsr);         // one step per bit
                        r    = {r[62:0], lfsr[0]};
                end
                return r;
        endfunction

        function automatic block_t random_block();
                sh_t      sh;
                payload_t pl;
                sh = random_bits(1) ? SH_CTRL : SH_DATA;
                pl = random_bits(64);
                return {sh, pl};
        endfunction

        task automatic check_value(input string name, input logic [65:0] expected,
                                   input logic [65:0] actual);
                n_checks++;
                if (actual !== expected)
                begin
                        n_errors++;
                        $display("ERROR %s expected %h actual %h", name, expected, actual);
                end
        endtask

        // one clock: check the outputs, advance the model, drive the next inputs
        task automatic step(input logic v, input block_t blk, input logic w, input logic r,
                            input rf_addr_t a, input rf_data_t d);
                sh_t    sh;
                logic   match;
                logic   brk;
                logic   reload;
                block_t exp_blk;
                block_t diff;
                @(posedge clock);
                #0.5;
                rd_capture = rd_data;
                sh    = m_tag_blk[NB_BLOCK-1 -: NB_SH];
                match = (b_mode == MODE_ALIGN && m_tag_tag) ||
                        (b_mode == MODE_CTRL && sh == SH_CTRL) ||
                        (b_mode == MODE_DATA && sh == SH_DATA) ||
                        (b_mode == MODE_ALL);
                brk     = m_tag_valid && !m_update && (b_burst != 0) && match;
                exp_blk = brk ? {sh, m_tag_blk[NB_PAYLOAD-1:0] ^ b_mask} : m_tag_blk;
                check_value({test_name, " valid/tag"}, {m_tag_valid, m_tag_tag},
                            {out_valid, out_tag});
                if (m_tag_valid)
                        check_value({test_name, " block"}, exp_blk, out_block);
                diff = m_tag_blk ^ exp_blk;
                if (m_clear)                    // clear beats this block
                begin
                        m_broken = '0;
                        m_flips  = '0;
                end
                else if (m_tag_valid)
                begin
                        m_broken = m_broken + (diff != 0);
                        m_flips  = m_flips + $countones(diff);
                end
                if (m_update)
                begin
                        b_mode   = s_mode;
                        b_mask   = s_mask;
                        b_burst  = s_burst;
                        b_period = s_period;
                        b_repeat = s_repeat;
                end
                else
                begin
                        reload = m_tag_valid && (b_period == 0) && (b_repeat != 0);
                        if (b_repeat != 0 && b_period == 0 && b_burst == 0)
                                b_repeat = b_repeat - 1'b1;     // valid or not
                        if (reload)
                        begin
                                b_burst  = s_burst;
                                b_period = s_period;
                        end
                        else
                        begin
                                if (brk)
                                        b_burst = b_burst - 1'b1;
                                if (m_tag_valid && b_period != 0)
                                        b_period = b_period - 1'b1;
                        end
                end
                in_valid = v;
                in_block = blk;
                wr       = w;
                rd       = r;
                addr     = a;
                wdata    = d;
                m_update = w && (a == RA_COMMIT);
                m_clear  = w && (a == RA_CLEAR);
                if (w)
                begin
                        case (a)
                                RA_MODE    : s_mode        = d[NB_MODE-1:0];
                                RA_MASK_LO : s_mask[31:0]  = d;
                                RA_MASK_HI : s_mask[63:32] = d;
                                RA_BURST   : s_burst       = d[NB_BURST_CNT-1:0];
                                RA_PERIOD  : s_period      = d[NB_PERIOD_CNT-1:0];
                                RA_REPEAT  : s_repeat      = d[NB_REPEAT_CNT-1:0];
                                default    : ;
                        endcase
                end
                m_tag_valid = v;
                m_tag_tag   = 1'b0;
                m_tag_blk   = blk;
                if (v)
                begin
                        if (m_am_cnt == AM_SPACING - 1)
                        begin
                                m_tag_tag = 1'b1;       // marker replaces the block
                                m_tag_blk = {SH_CTRL, AM_PAYLOAD};
                                m_am_cnt  = 0;
                        end
                        else
                                m_am_cnt++;
                end
        endtask

        task automatic traffic(input int n);
                logic   v;
                block_t b;
                for (int i = 0; i < n; i++)
                begin
                        v = (random_bits(4) < 13);      // about 80 % valid
                        b = random_block();
                        step(v, b, 1'b0, 1'b0, '0, '0);
                end
        endtask

        // register write with a random block alongside
        task automatic write_reg(input rf_addr_t a, input rf_data_t d);
                logic   v;
                block_t b;
                v = (random_bits(4) < 13);
                b = random_block();
                step(v, b, 1'b1, 1'b0, a, d);
        endtask

        task automatic read_reg(input rf_addr_t a, output rf_data_t data);
                repeat (3) step(1'b0, '0, 1'b0, 1'b0, '0, '0);  // statistics settle
                step(1'b0, '0, 1'b0, 1'b1, a, '0);
                step(1'b0, '0, 1'b0, 1'b0, '0, '0);
                data = rd_capture;
        endtask

        task automatic check_stats();
                rf_data_t data;
                read_reg(RA_BROKEN, data);
                check_value({test_name, " broken"}, m_broken, data);
                read_reg(RA_FLIPS, data);
                check_value({test_name, " flips"}, m_flips, data);
        endtask

        task automatic configure(input mode_t mode, input int burst, input int period,
                                 input int rpt);
                logic [63:0] mask;
                mask = random_bits(64);
                write_reg(RA_MODE, rf_data_t'(mode));
                write_reg(RA_MASK_LO, mask[31:0]);
                write_reg(RA_MASK_HI, mask[63:32]);
                write_reg(RA_BURST, rf_data_t'(burst));
                write_reg(RA_PERIOD, rf_data_t'(period));
                write_reg(RA_REPEAT, rf_data_t'(rpt));
                write_reg(RA_COMMIT, '0);       // commit lands mid-stream
        endtask

        task automatic run_mode(input mode_t mode, input int n);
                int burst;
                int period;
                int rpt;
                burst  = 1 + int'(random_bits(3));
                period = burst + int'(random_bits(5));
                rpt    = int'(random_bits(2));
                configure(mode, burst, period, rpt);
                traffic(n);
                check_stats();
        endtask

        initial
        begin
                rf_data_t data;
                rf_data_t quiet_ref;
                int       burst;
                int       period;
                int       rpt;
                int       n_assert;
                clock    = 1'b0;
                reset    = 1'b1;
                in_valid = 1'b0;
                in_block = '0;
                wr       = 1'b0;
                rd       = 1'b0;
                addr     = '0;
                wdata    = '0;
                lfsr     = 32'ha7c6de94;
                repeat (5) @(posedge clock);
                #0.5;
                reset = 1'b0;
                test_name = "default";          // pass-through, markers only
                traffic(len_short);
                check_stats();
                test_name = "mode_all";
                run_mode(MODE_ALL, len_short);
                test_name = "mode_ctrl";
                run_mode(MODE_CTRL, len_short);
                test_name = "mode_data";
                run_mode(MODE_DATA, len_short);
                // period long enough that every burst drains on markers
                test_name = "mode_align";
                burst  = 1 + int'(random_bits(1));
                period = 100 + int'(random_bits(5));
                rpt    = 1 + int'(random_bits(1));
                configure(MODE_ALIGN, burst, period, rpt);
                traffic(len_long);
                check_stats();
                quiet_ref = m_broken;           // repeats spent, count must hold
                traffic(len_short);
                read_reg(RA_BROKEN, data);
                check_value("mode_align quiet", quiet_ref, data);
                check_stats();
                test_name = "commit";
                burst  = 200 + int'(random_bits(5));
                period = burst + 100;
                rpt    = int'(random_bits(2));
                configure(MODE_ALL, burst, period, rpt);
                traffic(40);                    // long burst still running
                burst = 1 + int'(random_bits(3));
                write_reg(RA_BURST, rf_data_t'(burst));
                write_reg(RA_PERIOD, rf_data_t'(burst + int'(random_bits(4))));
                write_reg(RA_REPEAT, rf_data_t'(1 + random_bits(2)));
                // restart counters mid-stream, valid block on the update cycle
                step(1'b1, random_block(), 1'b1, 1'b0, RA_COMMIT, '0);
                traffic(100);
                check_stats();
                test_name = "clear";
                write_reg(RA_CLEAR, '0);
                read_reg(RA_BROKEN, data);
                check_value("clear broken", 32'd0, data);
                read_reg(RA_FLIPS, data);
                check_value("clear flips", 32'd0, data);
                n_assert = pcs_err_inject_top_i.payload_breaker_i.payload_breaker_chk_i.n_fail;
                $display("checks %0d, errors %0d, assertion failures %0d",
                         n_checks, n_errors, n_assert);
                if (n_errors == 0 && n_assert == 0)
                        $display("*** TEST PASSED ***");
                else
                        $display("*** TEST FAILED ***");
                $finish;
        end

        // watchdog
        initial
        begin
                int total_blocks;
                total_blocks = 5 * len_short + len_long + 400;  // plus register traffic
                #(total_blocks * 4 * 4);                        // blocks x 4 ns x 4
                $display("timeout, run did not finish within %0d block times", total_blocks * 4);
                $display("*** TEST FAILED ***");
                $finish;
        end

endmodule

/* pcs_err_inject_top.f */
hw/pcs_err_pkg.sv
hw/am_tagger.sv
hw/payload_breaker.sv
hw/break_monitor.sv
hw/err_rf.sv
hw/pcs_err_inject_top.sv
sim/payload_breaker_chk.sv
sim/pcs_err_inject_tb.sv
